// ==== hw/lsu_pkg.sv ====
`default_nettype none

package lsu_pkg;

   // --------------------
   // widths
   // --------------------
   localparam int ADDR_W   = 16;                // byte address
   localparam int DATA_W   = 32;
   localparam int BYTES_W  = DATA_W / 8;
   localparam int WORD_LSB = $clog2(BYTES_W);   // first word address bit

   typedef logic [ADDR_W-1:0]  addr_t;
   typedef logic [DATA_W-1:0]  data_t;
   typedef logic [BYTES_W-1:0] byteen_t;

   typedef enum logic [1:0] {
      SIZE_BYTE = 2'd0,
      SIZE_HALF = 2'd1,
      SIZE_WORD = 2'd2
   } access_size_e;

   // lanes touched by an aligned access at this offset
   function automatic byteen_t size_byteen(access_size_e size, logic [WORD_LSB-1:0] offset);
      byteen_t be;
      case (size)
         SIZE_BYTE: be = byteen_t'(4'b0001) << offset;
         SIZE_HALF: be = byteen_t'(4'b0011) << offset;
         SIZE_WORD: be = '1;
         default:   be = '0;    // encoding 3 is unused
      endcase
      return be;
   endfunction

endpackage

`default_nettype wire

// ==== hw/wb_pkg.sv ====
`default_nettype none

package wb_pkg;

   // --------------------
   // wishbone classic
   // --------------------
   localparam int WB_ADR_W = 16;   // byte address on the bus
   localparam int WB_DAT_W = 32;

   // one select bit per byte lane
   typedef logic [WB_DAT_W/8-1:0] wb_sel_t;

endpackage

`default_nettype wire

// ==== hw/stbuf_write_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

module stbuf_write_ctrl #(
   parameter int unsigned DEPTH = 4
) (
   input  logic                                               clk,
   input  logic                                               arst_n,

   // store from the pipeline
   input  logic                                               st_valid,
   input  lsu_pkg::addr_t                                     st_addr,
   input  lsu_pkg::access_size_e                              st_size,
   input  lsu_pkg::data_t                                     st_data,   // right aligned

   // entry state
   input  logic [DEPTH-1:0]                                   ent_vld,
   input  logic [DEPTH-1:0][lsu_pkg::ADDR_W-1:lsu_pkg::WORD_LSB] ent_addr,
   input  logic [$clog2(DEPTH)-1:0]                           rd_ptr,
   input  logic                                               drain_busy,
   input  logic                                               full,

   // write port into the entries
   output logic [DEPTH-1:0]                                   wr_en,
   output logic [lsu_pkg::ADDR_W-1:lsu_pkg::WORD_LSB]         wr_addr,
   output lsu_pkg::byteen_t                                   wr_byteen,
   output lsu_pkg::data_t                                     wr_data
);

   import lsu_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);

   logic [PTR_W-1:0]            wr_ptr;
   logic [DEPTH-1:0]            match;       // coalesce candidates
   logic [DEPTH-1:0]            alloc_vec;
   logic                        coalesce;
   logic [WORD_LSB-1:0]         st_off;

   // --------------------
   // lane alignment
   // --------------------
   assign st_off    = st_addr[WORD_LSB-1:0];
   assign wr_byteen = size_byteen(st_size, st_off);
   assign wr_data   = st_data << {st_off, 3'b000};   // move low bytes up to their lanes
   assign wr_addr   = st_addr[ADDR_W-1:WORD_LSB];

   // --------------------
   // coalesce match
   // --------------------
   // the head is off limits once its bus cycle is open
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         match[i] = ent_vld[i] && (ent_addr[i] == wr_addr) &&
                    !(drain_busy && (rd_ptr == PTR_W'(i)));
      end
   end

   assign coalesce  = |match;
   assign alloc_vec = {{(DEPTH-1){1'b0}}, 1'b1} << wr_ptr;

   assign wr_en = !st_valid ? '0 :
                  coalesce  ? match : alloc_vec;

   // write pointer only moves on a fresh allocation
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         wr_ptr <= '0;
      end else if (st_valid && !coalesce) begin
         wr_ptr <= wr_ptr + 1'b1;   // wraps, DEPTH is a power of two
      end
   end

   // upstream must hold off while the entries are all taken
   st_when_full_a: assert property (@(posedge clk) disable iff (!arst_n)
      st_valid |-> !full)
      else $error("store offered while the store buffer is full");

endmodule

`default_nettype wire

// ==== hw/stbuf_entries.sv ====
`timescale 1ns/100ps
`default_nettype none

module stbuf_entries #(
   parameter int unsigned DEPTH = 4
) (
   input  logic                                               clk,
   input  logic                                               arst_n,

   // write side
   input  logic [DEPTH-1:0]                                   wr_en,
   input  logic [lsu_pkg::ADDR_W-1:lsu_pkg::WORD_LSB]         wr_addr,
   input  lsu_pkg::byteen_t                                   wr_byteen,
   input  lsu_pkg::data_t                                     wr_data,

   // drain side
   input  logic                                               pop,
   input  logic [$clog2(DEPTH)-1:0]                           rd_ptr,

   output logic [DEPTH-1:0]                                   ent_vld,
   output logic [DEPTH-1:0][lsu_pkg::ADDR_W-1:lsu_pkg::WORD_LSB] ent_addr,
   output lsu_pkg::byteen_t [DEPTH-1:0]                       ent_byteen,
   output lsu_pkg::data_t [DEPTH-1:0]                         ent_data,
   output logic                                               full,
   output logic                                               empty
);

   import lsu_pkg::*;

   logic [DEPTH-1:0] clr;   // head being retired

   assign clr = pop ? ({{(DEPTH-1){1'b0}}, 1'b1} << rd_ptr) : '0;

   // --------------------
   // valid and byte enables
   // --------------------
   // cleared enables let a fresh allocation just OR in its own
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ent_vld    <= '0;
         ent_byteen <= '0;
      end else begin
         for (int i = 0; i < DEPTH; i++) begin
            if (clr[i]) begin
               ent_vld[i]    <= 1'b0;
               ent_byteen[i] <= '0;
            end else if (wr_en[i]) begin
               ent_vld[i]    <= 1'b1;
               ent_byteen[i] <= ent_byteen[i] | wr_byteen;
            end
         end
      end
   end

   // --------------------
   // address and data
   // --------------------
   always_ff @(posedge clk) begin
      for (int i = 0; i < DEPTH; i++) begin
         if (wr_en[i]) begin
            ent_addr[i] <= wr_addr;   // same word on a coalesce
            for (int b = 0; b < BYTES_W; b++) begin
               if (wr_byteen[b]) begin
                  ent_data[i][b*8 +: 8] <= wr_data[b*8 +: 8];
               end
            end
         end
      end
   end

   assign full  = &ent_vld;
   assign empty = ~|ent_vld;

   // a write into a live entry must be a coalesce
   for (genvar i = 0; i < DEPTH; i++) begin : g_chk
      alloc_addr_a: assert property (@(posedge clk) disable iff (!arst_n)
         (wr_en[i] && ent_vld[i]) |-> (ent_addr[i] == wr_addr))
         else $error("store overwrote live entry %0d holding another word", i);
   end

   pop_vld_a: assert property (@(posedge clk) disable iff (!arst_n)
      pop |-> ent_vld[rd_ptr])
      else $error("pop of an empty head entry");

endmodule

`default_nettype wire

// ==== hw/stbuf_drain_wb.sv ====
`timescale 1ns/100ps
`default_nettype none

module stbuf_drain_wb #(
   parameter int unsigned DEPTH = 4
) (
   input  logic                                               clk,
   input  logic                                               arst_n,

   input  logic [DEPTH-1:0]                                   ent_vld,
   input  logic [DEPTH-1:0][lsu_pkg::ADDR_W-1:lsu_pkg::WORD_LSB] ent_addr,
   input  lsu_pkg::byteen_t [DEPTH-1:0]                       ent_byteen,
   input  lsu_pkg::data_t [DEPTH-1:0]                         ent_data,

   output logic [$clog2(DEPTH)-1:0]                           rd_ptr,
   output logic                                               drain_busy,
   output logic                                               pop,

   // wishbone master, write only
   output logic                                               wb_cyc,
   output logic                                               wb_stb,
   output logic                                               wb_we,
   output logic [wb_pkg::WB_ADR_W-1:0]                        wb_adr,
   output logic [wb_pkg::WB_DAT_W-1:0]                        wb_dat_o,
   output wb_pkg::wb_sel_t                                    wb_sel,
   input  logic                                               wb_ack
);

   import lsu_pkg::*;
   import wb_pkg::*;

   typedef enum logic {
      ST_IDLE,
      ST_BUSY
   } state_e;

   state_e state;
   state_e state_nxt;

   // --------------------
   // bus FSM
   // --------------------
   always_comb begin
      state_nxt = state;
      case (state)
         ST_IDLE: if (ent_vld[rd_ptr]) state_nxt = ST_BUSY;
         ST_BUSY: if (wb_ack) state_nxt = ST_IDLE;   // one idle cycle after each write
         default: state_nxt = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state  <= ST_IDLE;
         rd_ptr <= '0;
      end else begin
         state <= state_nxt;
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
      end
   end

   assign drain_busy = (state == ST_BUSY);
   assign pop        = drain_busy && wb_ack;
   assign wb_cyc     = drain_busy;
   assign wb_stb     = drain_busy;
   assign wb_we      = drain_busy;

   // head entry is frozen while busy, so these hold by themselves
   assign wb_adr   = WB_ADR_W'({ent_addr[rd_ptr], {WORD_LSB{1'b0}}});
   assign wb_dat_o = WB_DAT_W'(ent_data[rd_ptr]);
   assign wb_sel   = wb_sel_t'(ent_byteen[rd_ptr]);

   bus_hold_a: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_dat_o) &&
                               $stable(wb_sel)))
      else $error("wishbone request changed before it was acknowledged");

endmodule

`default_nettype wire

// ==== hw/stbuf_fwd.sv ====
`timescale 1ns/100ps
`default_nettype none

module stbuf_fwd #(
   parameter int unsigned DEPTH = 4
) (
   input  lsu_pkg::addr_t                                     ld_addr,

   input  logic [DEPTH-1:0]                                   ent_vld,
   input  logic [DEPTH-1:0][lsu_pkg::ADDR_W-1:lsu_pkg::WORD_LSB] ent_addr,
   input  lsu_pkg::byteen_t [DEPTH-1:0]                       ent_byteen,
   input  lsu_pkg::data_t [DEPTH-1:0]                         ent_data,
   input  logic [$clog2(DEPTH)-1:0]                           rd_ptr,

   output lsu_pkg::byteen_t                                   fwd_byteen,
   output lsu_pkg::data_t                                     fwd_data
);

   import lsu_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);

   logic [ADDR_W-1:WORD_LSB] ld_word;
   logic [DEPTH-1:0]         hit;

   assign ld_word = ld_addr[ADDR_W-1:WORD_LSB];

   // --------------------
   // address compare
   // --------------------
   always_comb begin
      for (int i = 0; i < DEPTH; i++) begin
         hit[i] = ent_vld[i] && (ent_addr[i] == ld_word);
      end
   end

   // walk oldest to youngest from the head, later hits overwrite
   // so a draining copy loses to its re-allocated successor
   always_comb begin
      logic [PTR_W-1:0] idx;
      fwd_byteen = '0;
      fwd_data   = '0;
      for (int k = 0; k < DEPTH; k++) begin
         idx = rd_ptr + PTR_W'(k);
         for (int b = 0; b < BYTES_W; b++) begin
            if (hit[idx] && ent_byteen[idx][b]) begin
               fwd_byteen[b]        = 1'b1;
               fwd_data[b*8 +: 8]   = ent_data[idx][b*8 +: 8];
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== hw/stbuf_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module stbuf_top #(
   parameter int unsigned DEPTH = 4
) (
   input  logic                            clk,
   input  logic                            arst_n,

   // store input
   input  logic                            st_valid,
   input  lsu_pkg::addr_t                  st_addr,
   input  lsu_pkg::access_size_e           st_size,
   input  lsu_pkg::data_t                  st_data,
   output logic                            full,
   output logic                            empty,

   // load forward
   input  lsu_pkg::addr_t                  ld_addr,
   output lsu_pkg::byteen_t                fwd_byteen,
   output lsu_pkg::data_t                  fwd_data,

   // wishbone drain
   output logic                            wb_cyc,
   output logic                            wb_stb,
   output logic                            wb_we,
   output logic [wb_pkg::WB_ADR_W-1:0]     wb_adr,
   output logic [wb_pkg::WB_DAT_W-1:0]     wb_dat_o,
   output wb_pkg::wb_sel_t                 wb_sel,
   input  logic                            wb_ack
);

   import lsu_pkg::*;

   localparam int PTR_W = $clog2(DEPTH);

   // write port
   logic [DEPTH-1:0]                       wr_en;
   logic [ADDR_W-1:WORD_LSB]               wr_addr;
   byteen_t                                wr_byteen;
   data_t                                  wr_data;

   // entry state, shared by all readers
   logic [DEPTH-1:0]                       ent_vld;
   logic [DEPTH-1:0][ADDR_W-1:WORD_LSB]    ent_addr;
   byteen_t [DEPTH-1:0]                    ent_byteen;
   data_t [DEPTH-1:0]                      ent_data;

   logic [PTR_W-1:0]                       rd_ptr;
   logic                                   drain_busy;
   logic                                   pop;

   stbuf_write_ctrl #(.DEPTH(DEPTH)) write_ctrl_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .st_valid   (st_valid),
      .st_addr    (st_addr),
      .st_size    (st_size),
      .st_data    (st_data),
      .ent_vld    (ent_vld),
      .ent_addr   (ent_addr),
      .rd_ptr     (rd_ptr),
      .drain_busy (drain_busy),
      .full       (full),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_byteen  (wr_byteen),
      .wr_data    (wr_data)
   );

   stbuf_entries #(.DEPTH(DEPTH)) entries_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .wr_en      (wr_en),
      .wr_addr    (wr_addr),
      .wr_byteen  (wr_byteen),
      .wr_data    (wr_data),
      .pop        (pop),
      .rd_ptr     (rd_ptr),
      .ent_vld    (ent_vld),
      .ent_addr   (ent_addr),
      .ent_byteen (ent_byteen),
      .ent_data   (ent_data),
      .full       (full),
      .empty      (empty)
   );

   stbuf_drain_wb #(.DEPTH(DEPTH)) drain_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .ent_vld    (ent_vld),
      .ent_addr   (ent_addr),
      .ent_byteen (ent_byteen),
      .ent_data   (ent_data),
      .rd_ptr     (rd_ptr),
      .drain_busy (drain_busy),
      .pop        (pop),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_o   (wb_dat_o),
      .wb_sel     (wb_sel),
      .wb_ack     (wb_ack)
   );

   stbuf_fwd #(.DEPTH(DEPTH)) fwd_i (
      .ld_addr    (ld_addr),
      .ent_vld    (ent_vld),
      .ent_addr   (ent_addr),
      .ent_byteen (ent_byteen),
      .ent_data   (ent_data),
      .rd_ptr     (rd_ptr),
      .fwd_byteen (fwd_byteen),
      .fwd_data   (fwd_data)
   );

endmodule

`default_nettype wire

// ==== verif/tb_clkgen.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_clkgen #(
   parameter int PERIOD_NS  = 100,
   parameter int RST_CYCLES = 3
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // released on a falling edge, away from the sampling edge
   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== verif/stbuf_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module stbuf_tb;

   import lsu_pkg::*;
   import wb_pkg::*;

   localparam int DEPTH            = 4;
   localparam int PHASES           = 10;
   localparam int STORES_PER_PHASE = 30;
   localparam int STORE_CNT        = PHASES * STORES_PER_PHASE;
   localparam int TIMEOUT_CYCLES   = STORE_CNT * 8 + 200;

   logic clk;
   logic arst_n;

   logic                  st_valid;
   addr_t                 st_addr;
   access_size_e          st_size;
   data_t                 st_data;
   addr_t                 ld_addr;
   logic                  wb_ack;
   logic                  full;
   logic                  empty;
   byteen_t               fwd_byteen;
   data_t                 fwd_data;
   logic                  wb_cyc;
   logic                  wb_stb;
   logic                  wb_we;
   logic [WB_ADR_W-1:0]   wb_adr;
   logic [WB_DAT_W-1:0]   wb_dat_o;
   wb_sel_t               wb_sel;

   // reference model, index 0 is the oldest entry
   addr_t                 q_word[$];
   byteen_t               q_be[$];
   data_t                 q_dat[$];

   int                    exp_count;
   logic [WB_ADR_W-1:0]   exp_adr;
   wb_sel_t               exp_sel;
   data_t                 exp_dat;    // head data, disabled lanes zero
   data_t                 exp_mask;
   byteen_t               exp_fwd_be;
   data_t                 exp_fwd_dat;

   logic                  cyc_seen;   // bus request seen by the slave
   logic                  req_open;
   int                    ack_wait;
   int                    stores_sent;
   int                    coal_cnt;
   int                    full_seen;
   int                    stall_seen;
   int                    cycles;
   int                    mismatch_errs;
   int                    other_errs;

   tb_clkgen #(.PERIOD_NS(100), .RST_CYCLES(3)) clkgen_i (
      .clk    (clk),
      .arst_n (arst_n)
   );

   stbuf_top #(.DEPTH(DEPTH)) dut_i (
      .clk        (clk),
      .arst_n     (arst_n),
      .st_valid   (st_valid),
      .st_addr    (st_addr),
      .st_size    (st_size),
      .st_data    (st_data),
      .full       (full),
      .empty      (empty),
      .ld_addr    (ld_addr),
      .fwd_byteen (fwd_byteen),
      .fwd_data   (fwd_data),
      .wb_cyc     (wb_cyc),
      .wb_stb     (wb_stb),
      .wb_we      (wb_we),
      .wb_adr     (wb_adr),
      .wb_dat_o   (wb_dat_o),
      .wb_sel     (wb_sel),
      .wb_ack     (wb_ack)
   );

   // --------------------
   // model helpers
   // --------------------
   function automatic data_t lane_mask(input byteen_t be);
      data_t m;
      m = '0;
      for (int b = 0; b < BYTES_W; b++) begin
         if (be[b])
            m[b*8 +: 8] = 8'hff;
      end
      return m;
   endfunction

   // six words hit by stores, the seventh only by loads
   function automatic addr_t word_addr(input int idx);
      case (idx)
         0:       return 16'h0000;
         1:       return 16'h0004;
         2:       return 16'h0010;
         3:       return 16'h0400;
         4:       return 16'h8004;
         5:       return 16'hfffc;
         default: return 16'h1230;
      endcase
   endfunction

   task automatic model_store(input addr_t a, input access_size_e sz, input data_t d,
                              input logic busy);
      byteen_t be;
      data_t   lanes;
      data_t   m;
      addr_t   w;
      int      off;
      int      nb;
      int      hit;
      off   = int'(a[1:0]);
      nb    = (sz == SIZE_BYTE) ? 1 : (sz == SIZE_HALF) ? 2 : 4;
      w     = a & ~addr_t'(3);
      be    = '0;
      lanes = '0;
      hit   = -1;
      for (int b = 0; b < nb; b++) begin
         be[off+b] = 1'b1;
         lanes[(off+b)*8 +: 8] = d[b*8 +: 8];
      end
      // newest first, the head is skipped while its write is on the bus
      for (int i = q_word.size() - 1; i >= (busy ? 1 : 0); i--) begin
         if (hit < 0 && q_word[i] == w)
            hit = i;
      end
      if (hit >= 0) begin
         m          = lane_mask(be);
         q_dat[hit] = (q_dat[hit] & ~m) | (lanes & m);
         q_be[hit]  = q_be[hit] | be;
         coal_cnt++;
      end else begin
         q_word.push_back(w);
         q_be.push_back(be);
         q_dat.push_back(lanes);
      end
   endtask

   task automatic refresh_expect();
      data_t m;
      exp_count = q_word.size();
      exp_adr   = '0;
      exp_sel   = '0;
      exp_dat   = '0;
      if (exp_count != 0) begin
         exp_adr = q_word[0];
         exp_sel = q_be[0];
         exp_dat = q_dat[0] & lane_mask(q_be[0]);
      end
      exp_mask    = lane_mask(exp_sel);
      exp_fwd_be  = '0;
      exp_fwd_dat = '0;
      for (int i = 0; i < q_word.size(); i++) begin   // older first, newer overwrite
         if (q_word[i] == (ld_addr & ~addr_t'(3))) begin
            m           = lane_mask(q_be[i]);
            exp_fwd_be  = exp_fwd_be | q_be[i];
            exp_fwd_dat = (exp_fwd_dat & ~m) | (q_dat[i] & m);
         end
      end
   endtask

   // one falling edge: apply the last rising edge, answer the bus, drive new inputs
   task automatic cycle_step(input logic try_store);
      access_size_e sz;
      int           off;
      if (st_valid)
         model_store(st_addr, st_size, st_data, cyc_seen);
      if (cyc_seen && wb_ack) begin
         void'(q_word.pop_front());
         void'(q_be.pop_front());
         void'(q_dat.pop_front());
      end
      if (full)
         full_seen++;

      // wishbone slave with random wait states
      cyc_seen = wb_cyc && wb_stb;
      if (cyc_seen) begin
         if (!req_open) begin
            req_open = 1'b1;
            ack_wait = $urandom_range(5, 0);
         end else if (ack_wait > 0) begin
            ack_wait--;
         end
         if (ack_wait > 0)
            stall_seen++;
         wb_ack = (ack_wait == 0);
      end else begin
         req_open = 1'b0;
         wb_ack   = 1'b0;
      end

      st_valid = 1'b0;
      if (try_store && !full) begin
         sz = access_size_e'($urandom_range(2, 0));
         off = (sz == SIZE_BYTE) ? $urandom_range(3, 0) :
               (sz == SIZE_HALF) ? 2 * $urandom_range(1, 0) : 0;
         st_addr  = word_addr($urandom_range(5, 0)) | addr_t'(off);
         st_size  = sz;
         st_data  = $urandom;
         st_valid = 1'b1;
         stores_sent++;
      end
      ld_addr = word_addr($urandom_range(6, 0));
      refresh_expect();
   endtask

   // --------------------
   // checks
   // --------------------
   reset_state_a: assert property (@(posedge clk)
      $rose(arst_n) |-> (!wb_cyc && !wb_stb && empty && !full))
      else begin
         other_errs++;
         $display("bus or flags not idle after reset");
      end

   full_a: assert property (@(posedge clk) disable iff (!arst_n) full == (exp_count == DEPTH))
      else begin
         mismatch_errs++;
         $display("MISMATCH full: got %h exp %h", $sampled(full), $sampled(exp_count == DEPTH));
      end

   empty_a: assert property (@(posedge clk) disable iff (!arst_n) empty == (exp_count == 0))
      else begin
         mismatch_errs++;
         $display("MISMATCH empty: got %h exp %h", $sampled(empty), $sampled(exp_count == 0));
      end

   bus_form_a: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_cyc == wb_stb) && (!wb_cyc || wb_we))
      else begin
         other_errs++;
         $display("wishbone cyc, stb and we are out of step");
      end

   drain_nonempty_a: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_stb && wb_ack) |-> (exp_count != 0))
      else begin
         other_errs++;
         $display("bus write acknowledged while the model holds no entry");
      end

   drain_adr_a: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_stb && wb_ack) |-> (wb_adr == exp_adr))
      else begin
         mismatch_errs++;
         $display("MISMATCH wb_adr: got %h exp %h", $sampled(wb_adr), $sampled(exp_adr));
      end

   drain_sel_a: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_stb && wb_ack) |-> (wb_sel == exp_sel))
      else begin
         mismatch_errs++;
         $display("MISMATCH wb_sel: got %h exp %h", $sampled(wb_sel), $sampled(exp_sel));
      end

   drain_dat_a: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_stb && wb_ack) |-> ((wb_dat_o & exp_mask) == exp_dat))
      else begin
         mismatch_errs++;
         $display("MISMATCH wb_dat_o: got %h exp %h",
                  $sampled(wb_dat_o & exp_mask), $sampled(exp_dat));
      end

   // waiting request keeps its fields
   bus_hold_tb_a: assert property (@(posedge clk) disable iff (!arst_n)
      (wb_stb && !wb_ack) |=> (wb_stb && $stable(wb_adr) && $stable(wb_sel) &&
                               $stable(wb_dat_o)))
      else begin
         other_errs++;
         $display("wishbone request changed or dropped before its ack");
      end

   fwd_be_a: assert property (@(posedge clk) disable iff (!arst_n) fwd_byteen == exp_fwd_be)
      else begin
         mismatch_errs++;
         $display("MISMATCH fwd_byteen: got %h exp %h", $sampled(fwd_byteen), $sampled(exp_fwd_be));
      end

   fwd_dat_a: assert property (@(posedge clk) disable iff (!arst_n) fwd_data == exp_fwd_dat)
      else begin
         mismatch_errs++;
         $display("MISMATCH fwd_data: got %h exp %h", $sampled(fwd_data), $sampled(exp_fwd_dat));
      end

   // --------------------
   // run control
   // --------------------
   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("timeout after %0d cycles, the run did not complete", cycles);
         $display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs);
         $display("Finished with errors");
         $finish;
      end
   end

   initial begin
      int target;
      st_valid      = 1'b0;
      st_addr       = '0;
      st_size       = SIZE_BYTE;
      st_data       = '0;
      ld_addr       = '0;
      wb_ack        = 1'b0;
      cyc_seen      = 1'b0;
      req_open      = 1'b0;
      ack_wait      = 0;
      stores_sent   = 0;
      coal_cnt      = 0;
      full_seen     = 0;
      stall_seen    = 0;
      cycles        = 0;
      mismatch_errs = 0;
      other_errs    = 0;
      refresh_expect();
      void'($urandom(32'h4ed6_4bc0));

      @(posedge arst_n);
      // even phases push every cycle to fill up, odd phases trickle
      for (int p = 0; p < PHASES; p++) begin
         target = stores_sent + STORES_PER_PHASE;
         while (stores_sent < target) begin
            @(negedge clk);
            cycle_step((p % 2 == 0) || ($urandom_range(1, 0) == 1));
         end
         do begin
            @(negedge clk);
            cycle_step(1'b0);
         end while (!(empty && exp_count == 0 && !wb_cyc));
      end

      if (coal_cnt == 0) begin
         other_errs++;
         $display("no store was coalesced during the run");
      end
      if (full_seen == 0 || stall_seen == 0) begin
         other_errs++;
         $display("buffer never filled or the bus never stalled");
      end
      $display("errors: %0d mismatch, %0d other", mismatch_errs, other_errs);
      if (mismatch_errs == 0 && other_errs == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
hw/lsu_pkg.sv
hw/wb_pkg.sv
hw/stbuf_write_ctrl.sv
hw/stbuf_entries.sv
hw/stbuf_drain_wb.sv
hw/stbuf_fwd.sv
hw/stbuf_top.sv
verif/tb_clkgen.sv
verif/stbuf_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the store buffer testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f flist.f --top-module stbuf_tb \
   -o stbuf_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/stbuf_sim > sim.log 2>&1
cat sim.log

grep -q "Finished with errors" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
